// ==== src.f ====
verilog/conFieldPkg.sv
verilog/conBusPkg.sv
verilog/condDecoder.sv
verilog/magicDecoder.sv
verilog/conoRegisters.sv
verilog/cycleControl.sv
verilog/diagReadMux.sv
verilog/conTop.sv
test/clockGen.sv
test/conCtl_asserts.sv
test/conTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the conTb simulation with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f src.f --top-module conTb \
  --Mdir obj_dir -o conSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/conSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Test failed" "$LOG"; then
  exit 1
fi
if ! grep -q "Test passed" "$LOG"; then
  echo "No result line found in $LOG"
  exit 1
fi
exit 0

// ==== test/conTb.sv ====
`default_nettype none

module conTb import conFieldPkg::*, conBusPkg::*; ();

  // Control bits: eboxSync mboxCycReq mbXfer pageError skipSatisfied diagCtl diagRead fmXfer
  // Aux bits: selEn selDis selClr selSet delayReq ebusRel setPih piDismiss piDisable vmaSel
  typedef struct packed {
    condField    cond;
    magicField   magic;
    readbackWord ebus;
    memField     mem;
    logic [0:7]  ctl;
    logic [2:0]  code;
    diagSel      sel;
    logic [0:7]  strobe;
    logic [0:3]  cono;
    logic [0:2]  par;
    logic [0:3]  pag;
    logic [0:3]  sr;
    logic [0:4]  spec;
    logic [0:3]  ucode;
    logic [0:3]  cyc;
    logic [0:1]  runSt;
    readbackWord rb;
    logic [0:10] aux;
  } tableRow;

  localparam int numRows = 35;
  localparam int cycleLimit = 2 * numRows + 50;

  // Quiet aux value, PI disabled while run is low
  localparam logic [0:10] auxIdle = 11'b0000_0000_100;

  logic conCLK;
  logic CLK;
  condField cond;
  magicField magic;
  memField mem;
  readbackWord ebusData;
  logic diagRead;
  diagSel selCode;
  logic diagCtl;
  logic [2:0] diagCode;
  logic eboxSync;
  logic consoleControl;
  logic mboxCycReq;
  logic fmXfer;
  logic mbXfer;
  logic pageError;
  logic skipSatisfied;
  logic vmaSection0;
  logic specSaveFlags;
  logic conoApr;
  logic conoPi;
  logic conoPag;
  logic dataoApr;
  logic selEn;
  logic selDis;
  logic selClr;
  logic selSet;
  logic delayReq;
  logic ebusRel;
  logic [0:2] parityEnables;
  logic cacheLookEn;
  logic cacheLoadEn;
  logic ki10PagingMode;
  logic trapEn;
  logic [0:3] sr;
  logic kernelCycle;
  logic pcPlus1Inh;
  logic pxct;
  logic intDisable;
  logic eboxHalted;
  logic [0:3] ucodeState;
  logic memCycle;
  logic mboxWait;
  logic piCycle;
  logic piDismiss;
  logic setPih;
  logic longEn;
  logic run;
  logic start;
  logic piDisable;
  logic [1:0] vmaSel;
  readbackWord readback;

  tableRow rows [numRows];
  integer seed;
  int errors;
  int checks;
  int cycles;
  int curRow;

  clockGen clkGen (.conCLK(conCLK));

  conTop dut (
    .conCLK(conCLK), .CLK(CLK), .cond(cond), .magic(magic), .mem(mem),
    .ebusData(ebusData), .diagRead(diagRead), .diagSel(selCode), .diagCtl(diagCtl),
    .diagCode(diagCode), .eboxSync(eboxSync), .consoleControl(consoleControl),
    .mboxCycReq(mboxCycReq), .fmXfer(fmXfer), .mbXfer(mbXfer), .pageError(pageError),
    .skipSatisfied(skipSatisfied), .vmaSection0(vmaSection0),
    .specSaveFlags(specSaveFlags), .conoApr(conoApr), .conoPi(conoPi),
    .conoPag(conoPag), .dataoApr(dataoApr), .selEn(selEn), .selDis(selDis),
    .selClr(selClr), .selSet(selSet), .delayReq(delayReq), .ebusRel(ebusRel),
    .parityEnables(parityEnables), .cacheLookEn(cacheLookEn), .cacheLoadEn(cacheLoadEn),
    .ki10PagingMode(ki10PagingMode), .trapEn(trapEn), .sr(sr),
    .kernelCycle(kernelCycle), .pcPlus1Inh(pcPlus1Inh), .pxct(pxct),
    .intDisable(intDisable), .eboxHalted(eboxHalted), .ucodeState(ucodeState),
    .memCycle(memCycle), .mboxWait(mboxWait), .piCycle(piCycle), .piDismiss(piDismiss),
    .setPih(setPih), .longEn(longEn), .run(run), .start(start), .piDisable(piDisable),
    .vmaSel(vmaSel), .readback(readback)
  );

  task automatic compareBit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] row %0d %s got %h expected %h", curRow, name, got, exp);
    end
  endtask

  task automatic compareSr(input string name, input logic [0:3] got, input logic [0:3] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] row %0d %s got %h expected %h", curRow, name, got, exp);
    end
  endtask

  task automatic compareReadback(input string name, input readbackWord got,
                                 input readbackWord exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] row %0d %s got %h expected %h", curRow, name, got, exp);
    end
  endtask

  task automatic checkRow(input tableRow row);
    string strobeNames [8];
    string specNames [5];
    string auxNames [11];
    logic [0:7] strobes;
    logic [0:4] spec;
    logic [0:10] aux;
    strobeNames = '{"condLoadIr", "condSpecInstr", "condSrMagic", "condDiagFunc",
                    "condEboxState", "condEbusCtl", "condLongEn", "condVmaMagic"};
    specNames = '{"kernelCycle", "pcPlus1Inh", "pxct", "intDisable", "eboxHalted"};
    auxNames = '{"selEn", "selDis", "selClr", "selSet", "delayReq", "ebusRel", "setPih",
                 "piDismiss", "piDisable", "vmaSel[1]", "vmaSel[0]"};
    strobes = {dut.condLoadIr, dut.condSpecInstr, dut.condSrMagic, dut.condDiagFunc,
               dut.condEboxState, dut.condEbusCtl, dut.condLongEn, dut.condVmaMagic};
    spec = {kernelCycle, pcPlus1Inh, pxct, intDisable, eboxHalted};
    aux = {selEn, selDis, selClr, selSet, delayReq, ebusRel, setPih, piDismiss, piDisable,
           vmaSel[1], vmaSel[0]};
    for (int i = 0; i < 8; i++) begin
      compareBit(strobeNames[i], strobes[i], row.strobe[i]);
    end
    for (int i = 0; i < 5; i++) begin
      compareBit(specNames[i], spec[i], row.spec[i]);
    end
    for (int i = 0; i < 3; i++) begin
      compareBit($sformatf("parityEnables[%0d]", i), parityEnables[i], row.par[i]);
    end
    for (int i = 0; i < 11; i++) begin
      compareBit(auxNames[i], aux[i], row.aux[i]);
    end
    compareSr("cono", {conoApr, conoPi, conoPag, dataoApr}, row.cono);
    compareSr("pagEnables", {cacheLookEn, cacheLoadEn, ki10PagingMode, trapEn}, row.pag);
    compareSr("sr", sr, row.sr);
    compareSr("ucodeState", ucodeState, row.ucode);
    compareSr("cycle", {memCycle, mboxWait, piCycle, longEn}, row.cyc);
    compareBit("run", run, row.runSt[0]);
    compareBit("start", start, row.runSt[1]);
    compareReadback("readback", readback, row.rb);
  endtask

  task automatic fillTable();
    rows[0] = '{6'o14, 9'b0, 7'h0, 3'b0, 8'h00, 3'd0, 3'd0, 8'b1000_0000,
                4'b0, 3'b0, 4'b0, 4'b0, 5'b0, 4'b0, 4'b0, 2'b0, 7'h0, auxIdle};
    rows[1] = '{6'o16, 9'b001_101_100, 7'h0, 3'b0, 8'h00, 3'd0, 3'd0, 8'b0010_0000,
                4'b0, 3'b0, 4'b0, 4'b0, 5'b0, 4'b0, 4'b0, 2'b0, 7'h0, auxIdle};
    rows[2] = '{6'o15, 9'b010_010_010, 7'h0, 3'b0, 8'h00, 3'd0, 3'd0, 8'b0100_0000,
                4'b0, 3'b0, 4'b0, 4'b1110, 5'b0, 4'b0, 4'b0, 2'b0, 7'h0, auxIdle};
    // CONO PI with sync, then CONO PAG, then CONO PI without sync
    rows[3] = '{6'o20, 9'b000_001_101, 7'b101_0000, 3'b0, 8'b1000_0000, 3'd0, 3'd0,
                8'b0001_0000, 4'b0100, 3'b0, 4'b0, 4'b1110, 5'b10101, 4'b0, 4'b0, 2'b0,
                7'h0, auxIdle};
    rows[4] = '{6'o20, 9'b000_001_110, 7'b110_1000, 3'b0, 8'h00, 3'd0, 3'd0,
                8'b0001_0000, 4'b0010, 3'b101, 4'b0, 4'b1110, 5'b10101, 4'b0, 4'b0, 2'b0,
                7'h0, auxIdle};
    rows[5] = '{6'o20, 9'b000_001_101, 7'b010_0000, 3'b0, 8'h00, 3'd0, 3'd0,
                8'b0001_0000, 4'b0, 3'b101, 4'b1110, 4'b1110, 5'b10101, 4'b0, 4'b0, 2'b0,
                7'h0, auxIdle};
    rows[6] = '{6'o00, 9'b0, 7'h0, 3'b0, 8'b0000_0010, 3'd0, diagSelEnables, 8'b0,
                4'b0, 3'b101, 4'b1110, 4'b1110, 5'b10101, 4'b0, 4'b0, 2'b0,
                7'b101_0110, auxIdle};
    rows[7] = '{6'o21, 9'b010_010_010, 7'h0, 3'b0, 8'h00, 3'd0, 3'd0, 8'b0000_1000,
                4'b0, 3'b101, 4'b1110, 4'b1110, 5'b10101, 4'b0, 4'b0, 2'b0,
                7'h0, auxIdle};
    rows[8] = '{6'o21, 9'b001_100_000, 7'h0, 3'b0, 8'h00, 3'd0, 3'd0, 8'b0000_1000,
                4'b0, 3'b101, 4'b1110, 4'b1110, 5'b10101, 4'b1001, 4'b0, 2'b0,
                7'h0, auxIdle};
    rows[9] = '{6'o00, 9'b0, 7'h0, 3'b0, 8'b0000_0010, 3'd0, diagSelCycle, 8'b0,
                4'b0, 3'b101, 4'b1110, 4'b1110, 5'b10101, 4'b1100, 4'b0, 2'b0,
                7'b011_1000, auxIdle};
    for (int r = 10; r < numRows; r++) begin
      rows[r] = '{6'o00, 9'b0, 7'h0, 3'b0, 8'h00, 3'd0, 3'd0, 8'b0,
                  4'b0, 3'b101, 4'b1110, 4'b1110, 5'b10101, 4'b1100, 4'b0, 2'b0,
                  7'h0, auxIdle};
      if (r >= 17) begin
        rows[r].spec = (r >= 21) ? 5'b01000 : 5'b00000;
      end
    end
    // Memory cycle, then PI cycle, then long enable
    rows[10].ctl = 8'b0100_0000;
    rows[10].aux = 11'b0000_0000_111;
    rows[11].mem = 3'b001;
    rows[11].cyc = 4'b1100;
    rows[12].ctl = 8'b0010_0000;
    rows[12].cyc = 4'b1000;
    rows[14].ctl = 8'b0100_0000;
    rows[14].aux = 11'b0000_0000_111;
    rows[15].ctl = 8'b0001_0000;
    rows[15].cyc = 4'b1000;
    rows[16].cond = 6'o15;
    rows[16].magic = 9'b100_000_000;
    rows[16].strobe = 8'b0100_0000;
    rows[17].cyc = 4'b0010;
    rows[18].ctl = 8'b0000_1000;
    rows[18].cyc = 4'b0010;
    rows[19].cond = 6'o15;
    rows[19].magic = 9'b100_000_000;
    rows[19].strobe = 8'b0100_0000;
    rows[20].cond = 6'o15;
    rows[20].magic = 9'b001_000_000;
    rows[20].strobe = 8'b0100_0000;
    rows[20].cyc = 4'b0010;
    rows[20].aux = 11'b0000_0010_100;
    rows[21].cond = 6'o25;
    rows[21].strobe = 8'b0000_0010;
    rows[22].ctl = 8'b0000_0100;
    rows[22].code = diagCodeSetRun;
    rows[22].cyc = 4'b0001;
    rows[23].cyc = 4'b0001;
    rows[24].ctl = 8'b0100_0000;
    rows[24].cyc = 4'b0001;
    rows[24].aux = 11'b0000_0000_111;
    rows[25].ctl = 8'b0000_0001;
    rows[25].cyc = 4'b1000;
    // Run delay line
    rows[26].ctl = 8'b0000_0100;
    rows[26].code = diagCodeContinue;
    rows[27].ctl = 8'b0000_0100;
    rows[27].code = diagCodeClrRun;
    rows[28].cond = 6'o20;
    rows[28].magic = 9'b000_100_000;
    rows[28].strobe = 8'b0001_0000;
    rows[28].aux[4] = 1'b1;
    rows[29].ctl = 8'b0000_0010;
    rows[29].sel = diagSelCycle;
    rows[29].rb = 7'b011_1001;
    for (int r = 25; r < 30; r++) begin
      rows[r].runSt[0] = 1'b1;
      rows[r].aux[8] = 1'b0;
    end
    rows[29].runSt[1] = 1'b1;
    rows[30].cond = 6'o35;
    rows[30].aux = 11'b0000_0000_110;
    rows[31].cond = 6'o30;
    rows[31].strobe = 8'b0000_0001;
    rows[32].cond = 6'o20;
    rows[32].magic = 9'b000_001_111;
    rows[32].strobe = 8'b0001_0000;
    rows[32].cono = 4'b0001;
    rows[33].cond = 6'o20;
    rows[33].magic = 9'b000_001_100;
    rows[33].ebus = 7'b001_0100;
    rows[33].ctl = 8'b1000_0000;
    rows[33].strobe = 8'b0001_0000;
    rows[33].cono = 4'b1000;
    rows[33].aux = 11'b1010_0000_100;
    rows[34].cond = 6'o22;
    rows[34].magic = 9'b001_000_000;
    rows[34].ctl = 8'b1000_0000;
    rows[34].strobe = 8'b0000_0100;
    rows[34].aux = 11'b0000_0100_100;
  endtask

  task automatic applyRow(input tableRow row);
    logic [31:0] randWord;
    randWord = $random(seed);
    cond <= row.cond;
    magic <= row.magic;
    mem <= row.mem;
    // EBUS carries filler unless the row sets it
    ebusData <= (row.ebus == '0) ? randWord[6:0] : row.ebus;
    {eboxSync, mboxCycReq, mbXfer, pageError, skipSatisfied, diagCtl, diagRead, fmXfer}
      <= row.ctl;
    diagCode <= row.code;
    selCode <= row.sel;
  endtask

  always @(posedge conCLK) begin
    cycles = cycles + 1;
    if (cycles >= cycleLimit) begin
      $display("Timeout after %0d cycles, table did not finish", cycles);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    seed = 32'hf767_d28d;
    errors = 0;
    checks = 0;
    cycles = 0;
    curRow = -1;
    CLK <= 1'b1;
    cond <= '0;
    magic <= '0;
    mem <= '0;
    ebusData <= '0;
    diagRead <= 1'b0;
    selCode <= '0;
    diagCtl <= 1'b0;
    diagCode <= 3'd0;
    eboxSync <= 1'b0;
    consoleControl <= 1'b0;
    mboxCycReq <= 1'b0;
    fmXfer <= 1'b0;
    mbXfer <= 1'b0;
    pageError <= 1'b0;
    skipSatisfied <= 1'b0;
    vmaSection0 <= 1'b0;
    specSaveFlags <= 1'b0;
    fillTable();

    // A decodable code during reset must stay quiet
    repeat (4) @(posedge conCLK);
    cond <= 6'o15;
    magic <= 9'b010_000_000;
    @(negedge conCLK);
    compareBit("condSpecInstr", dut.condSpecInstr, 1'b0);
    compareBit("kernelCycle", kernelCycle, 1'b0);
    repeat (4) @(posedge conCLK);
    cond <= '0;
    magic <= '0;
    CLK <= 1'b0;

    for (int r = 0; r < numRows; r++) begin
      @(posedge conCLK);
      applyRow(rows[r]);
      @(negedge conCLK);
      curRow = r;
      checkRow(rows[r]);
    end

    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== test/conCtl_asserts.sv ====
`default_nettype none

module conCtlAsserts (
  input wire       conCLK,
  input wire       CLK,
  input wire       conoApr,
  input wire       conoPi,
  input wire       conoPag,
  input wire       dataoApr,
  input wire [0:2] parityEnables,
  input wire [0:3] sr,
  input wire [0:3] ucodeState,
  input wire       memCycle,
  input wire       piCycle,
  input wire       longEn,
  input wire       run,
  input wire       start
);

  // At most one diagnostic I/O strobe
  conoOneHot: assert property (@(posedge conCLK) disable iff (CLK)
    $onehot0({conoApr, conoPi, conoPag, dataoApr}))
    else $error("more than one CONO or DATAO strobe active");

  strobesLowInReset: assert property (@(posedge conCLK)
    CLK |-> !(conoApr || conoPi || conoPag || dataoApr))
    else $error("CONO strobe active during reset");

  stateLowInReset: assert property (@(posedge conCLK)
    CLK |-> (parityEnables == 3'b000 && sr == 4'b0000 && ucodeState == 4'b0000
             && !memCycle && !piCycle && !longEn && !run && !start))
    else $error("registered output not low during reset");

endmodule

bind conTop conCtlAsserts conAsserts (.*);

`default_nettype wire

// ==== test/clockGen.sv ====
`default_nettype none

module clockGen (
  output logic conCLK
);

  initial begin
    conCLK = 1'b0;
  end

  // Period of 4
  always #2 conCLK = ~conCLK;

endmodule

`default_nettype wire

// ==== verilog/conTop.sv ====
`default_nettype none

module conTop import conFieldPkg::*, conBusPkg::*; (
  input  wire                    conCLK,
  input  wire                    CLK,
  input  wire condField          cond,
  input  wire magicField         magic,
  input  wire memField           mem,
  input  wire readbackWord       ebusData,
  input  wire                    diagRead,
  input  wire conBusPkg::diagSel diagSel,
  input  wire                    diagCtl,
  input  wire [2:0]              diagCode,
  input  wire                    eboxSync,
  input  wire                    consoleControl,
  input  wire                    mboxCycReq,
  input  wire                    fmXfer,
  input  wire                    mbXfer,
  input  wire                    pageError,
  input  wire                    skipSatisfied,
  input  wire                    vmaSection0,
  input  wire                    specSaveFlags,
  output logic                   conoApr,
  output logic                   conoPi,
  output logic                   conoPag,
  output logic                   dataoApr,
  output logic                   selEn,
  output logic                   selDis,
  output logic                   selClr,
  output logic                   selSet,
  output logic                   delayReq,
  output logic                   ebusRel,
  output logic [0:2]             parityEnables,
  output logic                   cacheLookEn,
  output logic                   cacheLoadEn,
  output logic                   ki10PagingMode,
  output logic                   trapEn,
  output logic [0:3]             sr,
  output logic                   kernelCycle,
  output logic                   pcPlus1Inh,
  output logic                   pxct,
  output logic                   intDisable,
  output logic                   eboxHalted,
  output logic [0:3]             ucodeState,
  output logic                   memCycle,
  output logic                   mboxWait,
  output logic                   piCycle,
  output logic                   piDismiss,
  output logic                   setPih,
  output logic                   longEn,
  output logic                   run,
  output logic                   start,
  output logic                   piDisable,
  output logic [1:0]             vmaSel,
  output readbackWord            readback
);

  logic condLoadIr;
  logic condSpecInstr;
  logic condSrMagic;
  logic condDiagFunc;
  logic condEboxState;
  logic condEbusCtl;
  logic condLongEn;
  logic condVmaMagic;
  logic [0:condGroupWidth-1] condGroupActive;

  // VMA loads with each memory request
  condDecoder condDec (
    .loadVma(mboxCycReq),
    .*
  );

  magicDecoder magicDec (.*);

  conoRegisters conoRegs (.*);

  cycleControl cycleCtl (.*);

  diagReadMux readMux (.*);

endmodule

`default_nettype wire

// ==== verilog/diagReadMux.sv ====
`default_nettype none

module diagReadMux import conFieldPkg::*, conBusPkg::*; (
  input  wire                        diagRead,
  input  wire conBusPkg::diagSel     diagSel,
  input  wire [0:2]                  parityEnables,
  input  wire                        cacheLookEn,
  input  wire                        cacheLoadEn,
  input  wire                        ki10PagingMode,
  input  wire                        trapEn,
  input  wire [0:3]                  sr,
  input  wire                        kernelCycle,
  input  wire                        pcPlus1Inh,
  input  wire                        pxct,
  input  wire                        intDisable,
  input  wire                        eboxHalted,
  input  wire [0:3]                  ucodeState,
  input  wire                        memCycle,
  input  wire                        mboxWait,
  input  wire                        piCycle,
  input  wire                        piDismiss,
  input  wire                        setPih,
  input  wire                        longEn,
  input  wire                        run,
  input  wire                        start,
  input  wire                        piDisable,
  input  wire                        delayReq,
  input  wire                        ebusRel,
  input  wire                        condLoadIr,
  input  wire                        condVmaMagic,
  input  wire [1:0]                  vmaSel,
  input  wire [0:condGroupWidth-1]   condGroupActive,
  output readbackWord                readback
);

  // First element of each word lands on EBUS bit 18
  always_comb begin
    readback = '0;
    if (diagRead) begin
      case (diagSel)
        diagSelEnables: readback = {parityEnables, trapEn, cacheLookEn, cacheLoadEn, 1'b0};
        diagSelSpec: begin
          readback = {kernelCycle, pcPlus1Inh, pxct, intDisable, eboxHalted,
                      ki10PagingMode, longEn};
        end
        // memory cycle reads back inverted
        diagSelCycle: readback = {piCycle, ~memCycle, ucodeState, run};
        diagSelSr: readback = {sr, delayReq, ebusRel, 1'b0};
        diagSelDecode: begin
          readback = {condGroupActive, condVmaMagic, vmaSel[1], vmaSel[0], condLoadIr};
        end
        diagSelStrobe: readback = {mboxWait, piDismiss, setPih, start, piDisable, 2'b00};
        default: readback = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== verilog/cycleControl.sv ====
`default_nettype none

module cycleControl import conFieldPkg::*, conBusPkg::*; (
  input  wire            conCLK,
  input  wire            CLK,
  input  wire            mboxCycReq,
  input  wire            fmXfer,
  input  wire            mbXfer,
  input  wire            pageError,
  input  wire            skipSatisfied,
  input  wire            specSaveFlags,
  input  wire            eboxSync,
  input  wire            vmaSection0,
  input  wire            condSpecInstr,
  input  wire            condLongEn,
  input  wire magicField magic,
  input  wire memField   mem,
  input  wire            diagCtl,
  input  wire [2:0]      diagCode,
  input  wire            eboxHalted,
  output logic           memCycle,
  output logic           mboxWait,
  output logic           piCycle,
  output logic           piDismiss,
  output logic           setPih,
  output logic           longEn,
  output logic           run,
  output logic           start,
  output logic           piDisable
);

  logic xfer;
  logic specFlagMagic2;
  logic clrPiCycle;
  logic setRun;
  logic clrRun;
  logic continueReq;
  logic [0:1] runStage;
  logic [0:1] startStage;

  always_comb begin
    xfer = fmXfer || mbXfer;
    specFlagMagic2 = condSpecInstr && magic[2];
    clrPiCycle = (specSaveFlags && piCycle && eboxSync) || specFlagMagic2;
    setPih = clrPiCycle;
    piDismiss = specFlagMagic2 && !piCycle && !eboxSync;
    mboxWait = mem[memWaitBit] && memCycle;
    piDisable = !run || eboxHalted;
    setRun = diagCtl && diagCode == diagCodeSetRun;
    clrRun = diagCtl && diagCode == diagCodeClrRun;
    continueReq = diagCtl && diagCode == diagCodeContinue;
  end

  // Set terms win over clear terms
  always_ff @(posedge conCLK or posedge CLK) begin
    if (CLK) begin
      memCycle <= 1'b0;
      piCycle <= 1'b0;
      longEn <= 1'b0;
    end else begin
      memCycle <= mboxCycReq || (memCycle && !xfer && !pageError);
      piCycle <= (condSpecInstr && magic[0]) || (piCycle && !skipSatisfied && !clrPiCycle);
      longEn <= (condLongEn && !vmaSection0) || (longEn && !mboxCycReq);
    end
  end

  // Three-stage delay, first run stage holds the requested level
  always_ff @(posedge conCLK or posedge CLK) begin
    if (CLK) begin
      runStage <= '0;
      run <= 1'b0;
      startStage <= '0;
      start <= 1'b0;
    end else begin
      runStage[0] <= setRun || (runStage[0] && !clrRun);
      runStage[1] <= runStage[0];
      run <= runStage[1];
      startStage[0] <= continueReq;
      startStage[1] <= startStage[0];
      start <= startStage[1];
    end
  end

endmodule

`default_nettype wire

// ==== verilog/conoRegisters.sv ====
`default_nettype none

module conoRegisters import conFieldPkg::*, conBusPkg::*; (
  input  wire              conCLK,
  input  wire              CLK,
  input  wire              conoPi,
  input  wire              conoPag,
  input  wire              condSrMagic,
  input  wire              condSpecInstr,
  input  wire              condEboxState,
  input  wire magicField   magic,
  input  wire readbackWord ebusData,
  output logic [0:2]       parityEnables,
  output logic             cacheLookEn,
  output logic             cacheLoadEn,
  output logic             ki10PagingMode,
  output logic             trapEn,
  output logic [0:3]       sr,
  output logic             kernelCycle,
  output logic             pcPlus1Inh,
  output logic             pxct,
  output logic             intDisable,
  output logic             eboxHalted,
  output logic [0:3]       ucodeState
);

  // Write even parity for address, data and directory
  always_ff @(posedge conCLK or posedge CLK) begin
    if (CLK) begin
      parityEnables <= '0;
    end else if (conoPi) begin
      parityEnables <= {ebusData[ebusParAdr], ebusData[ebusParData], ebusData[ebusParDir]};
    end
  end

  // Cache and paging setup
  always_ff @(posedge conCLK or posedge CLK) begin
    if (CLK) begin
      cacheLookEn <= 1'b0;
      cacheLoadEn <= 1'b0;
      ki10PagingMode <= 1'b0;
      trapEn <= 1'b0;
    end else if (conoPag) begin
      cacheLookEn <= ebusData[ebusCacheLook];
      cacheLoadEn <= ebusData[ebusCacheLoad];
      ki10PagingMode <= ebusData[ebusPagingEn];
      trapEn <= ebusData[ebusTrapEn];
    end
  end

  // SR bits 2 and 3 are merged from overlapping MAGIC pairs
  always_ff @(posedge conCLK or posedge CLK) begin
    if (CLK) begin
      sr <= '0;
    end else if (condSrMagic) begin
      sr <= {magic[5],
             magic[6],
             (magic[3] || magic[7]) && (magic[2] || magic[7]),
             (magic[4] || magic[8]) && (magic[3] || magic[7])};
    end
  end

  // Special instruction flags
  always_ff @(posedge conCLK or posedge CLK) begin
    if (CLK) begin
      kernelCycle <= 1'b0;
      pcPlus1Inh <= 1'b0;
      pxct <= 1'b0;
      intDisable <= 1'b0;
      eboxHalted <= 1'b0;
    end else if (condSpecInstr) begin
      kernelCycle <= magic[1];
      pcPlus1Inh <= magic[2];
      pxct <= magic[4];
      intDisable <= magic[5];
      eboxHalted <= magic[7];
    end
  end

  // Odd bit sets, the next bit holds, neither clears
  always_ff @(posedge conCLK or posedge CLK) begin
    if (CLK) begin
      ucodeState <= '0;
    end else if (condEboxState) begin
      for (int i = 0; i < 4; i++) begin
        ucodeState[i] <= magic[2*i+1] || (magic[2*i+2] && ucodeState[i]);
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/magicDecoder.sv ====
`default_nettype none

module magicDecoder import conFieldPkg::*, conBusPkg::*; (
  input  wire magicField   magic,
  input  wire              condDiagFunc,
  input  wire              condEbusCtl,
  input  wire              consoleControl,
  input  wire              eboxSync,
  input  wire readbackWord ebusData,
  output logic             conoApr,
  output logic             conoPi,
  output logic             conoPag,
  output logic             dataoApr,
  output logic             selEn,
  output logic             selDis,
  output logic             selClr,
  output logic             selSet,
  output logic             delayReq,
  output logic             ebusRel
);

  logic [2:0] func;
  logic [2:0] sub;
  logic diagFunc0xx;
  logic func01x;

  always_comb begin
    func = magic[magicFuncLo:magicFuncHi];
    sub = magic[magicSubLo:magicSubHi];
    // Diagnostic functions 0xx need MAGIC bit 2 low
    diagFunc0xx = condDiagFunc && !magic[2];
    func01x = diagFunc0xx && func == magicFunc01 && !consoleControl;
  end

  always_comb begin
    conoApr = func01x && sub == magicConoApr && eboxSync;
    conoPi = func01x && sub == magicConoPi && eboxSync;
    conoPag = func01x && sub == magicConoPag;
    dataoApr = func01x && sub == magicDataoApr;
  end

  // APR select strobes ride on CONO APR
  always_comb begin
    selEn = conoApr && ebusData[ebusSelEn];
    selDis = conoApr && ebusData[ebusSelDis];
    selClr = conoApr && ebusData[ebusSelClr];
    selSet = conoApr && ebusData[ebusSelSet];
  end

  always_comb begin
    delayReq = condDiagFunc && magic[magicFuncLo];
    ebusRel = condEbusCtl && magic[2] && eboxSync;
  end

endmodule

`default_nettype wire

// ==== verilog/condDecoder.sv ====
`default_nettype none

module condDecoder import conFieldPkg::*; (
  input  wire                        conCLK,
  input  wire                        CLK,
  input  wire condField              cond,
  input  wire                        loadVma,
  output logic                       condLoadIr,
  output logic                       condSpecInstr,
  output logic                       condSrMagic,
  output logic                       condDiagFunc,
  output logic                       condEboxState,
  output logic                       condEbusCtl,
  output logic                       condLongEn,
  output logic                       condVmaMagic,
  output logic [1:0]                 vmaSel,
  output logic [0:condGroupWidth-1]  condGroupActive
);

  logic [condGroupWidth-1:0] group;
  logic [condGroupWidth-1:0] code;
  logic en10;
  logic en20;
  logic en30;

  // Upper digit selects the group
  always_comb begin
    group = cond[0:condGroupWidth-1];
    code = cond[condGroupWidth:condWidth-1];
    en10 = !CLK && group == condGroup10;
    en20 = !CLK && group == condGroup20;
    en30 = !CLK && group == condGroup30;
  end

  // Codes share names with the strobe ports, hence the package scope
  always_comb begin
    condLoadIr = en10 && code == conFieldPkg::condLoadIr;
    condSpecInstr = en10 && code == conFieldPkg::condSpecInstr;
    condSrMagic = en10 && code == conFieldPkg::condSrMagic;
    condDiagFunc = en20 && code == conFieldPkg::condDiagFunc;
    condEboxState = en20 && code == conFieldPkg::condEboxState;
    condEbusCtl = en20 && code == conFieldPkg::condEbusCtl;
    condLongEn = en20 && code == conFieldPkg::condLongEn;
    condVmaMagic = en30 && code < condVmaDec;
    vmaSel[1] = !CLK && ((en30 && code == condVmaDec) || loadVma);
    vmaSel[0] = !CLK && ((en30 && code == condVmaInc) || loadVma);
  end

  // Group enables held for diagnostic readback
  always_ff @(posedge conCLK or posedge CLK) begin
    if (CLK) begin
      condGroupActive <= '0;
    end else begin
      condGroupActive <= {en10, en20, en30};
    end
  end

endmodule

`default_nettype wire

// ==== verilog/conBusPkg.sv ====
`default_nettype none

package conBusPkg;

  localparam int ebusLo = 18;
  localparam int diagSelWidth = 3;
  localparam int readbackWidth = 7;

  // CONO PI parity enables
  localparam int ebusParAdr = 18;
  localparam int ebusParData = 19;
  localparam int ebusParDir = 20;

  // CONO PAG
  localparam int ebusCacheLook = 18;
  localparam int ebusCacheLoad = 19;
  localparam int ebusPagingEn = 21;
  localparam int ebusTrapEn = 22;

  // CONO APR select bits
  localparam int ebusSelEn = 20;
  localparam int ebusSelDis = 21;
  localparam int ebusSelClr = 22;
  localparam int ebusSelSet = 23;

  // Readback select codes, 6 and 7 read zero
  localparam logic [diagSelWidth-1:0] diagSelEnables = 3'd0;
  localparam logic [diagSelWidth-1:0] diagSelSpec = 3'd1;
  localparam logic [diagSelWidth-1:0] diagSelCycle = 3'd2;
  localparam logic [diagSelWidth-1:0] diagSelSr = 3'd3;
  localparam logic [diagSelWidth-1:0] diagSelDecode = 3'd4;
  localparam logic [diagSelWidth-1:0] diagSelStrobe = 3'd5;

  // Diagnostic control function codes
  localparam logic [2:0] diagCodeClrRun = 3'd0;
  localparam logic [2:0] diagCodeSetRun = 3'd1;
  localparam logic [2:0] diagCodeContinue = 3'd2;

  typedef logic [diagSelWidth-1:0] diagSel;
  typedef logic [ebusLo:ebusLo+readbackWidth-1] readbackWord;

endpackage

`default_nettype wire

// ==== verilog/conFieldPkg.sv ====
`default_nettype none

package conFieldPkg;

  localparam int condWidth = 6;
  localparam int condGroupWidth = 3;
  localparam int magicWidth = 9;
  localparam int memWidth = 3;

  // Upper COND digit
  localparam logic [condGroupWidth-1:0] condGroup10 = 3'd1;
  localparam logic [condGroupWidth-1:0] condGroup20 = 3'd2;
  localparam logic [condGroupWidth-1:0] condGroup30 = 3'd3;

  // Group 10 codes
  localparam logic [condGroupWidth-1:0] condFmWrite = 3'd0;
  localparam logic [condGroupWidth-1:0] condLoadIr = 3'd4;
  localparam logic [condGroupWidth-1:0] condSpecInstr = 3'd5;
  localparam logic [condGroupWidth-1:0] condSrMagic = 3'd6;
  localparam logic [condGroupWidth-1:0] condSelVma = 3'd7;

  // Group 20 codes
  localparam logic [condGroupWidth-1:0] condDiagFunc = 3'd0;
  localparam logic [condGroupWidth-1:0] condEboxState = 3'd1;
  localparam logic [condGroupWidth-1:0] condEbusCtl = 3'd2;
  localparam logic [condGroupWidth-1:0] condLongEn = 3'd5;

  // Group 30 codes, everything below VMA DEC is a VMA magic code
  localparam logic [condGroupWidth-1:0] condVmaDec = 3'd5;
  localparam logic [condGroupWidth-1:0] condVmaInc = 3'd6;
  localparam logic [condGroupWidth-1:0] condLoadVmaHeld = 3'd7;

  // MAGIC subfields
  localparam int magicFuncLo = 3;
  localparam int magicFuncHi = 5;
  localparam int magicSubLo = 6;
  localparam int magicSubHi = 8;
  localparam int memWaitBit = 2;

  localparam logic [2:0] magicFunc01 = 3'd1;
  localparam logic [2:0] magicConoApr = 3'd4;
  localparam logic [2:0] magicConoPi = 3'd5;
  localparam logic [2:0] magicConoPag = 3'd6;
  localparam logic [2:0] magicDataoApr = 3'd7;

  typedef logic [0:condWidth-1] condField;
  typedef logic [0:magicWidth-1] magicField;
  typedef logic [0:memWidth-1] memField;

endpackage

`default_nettype wire
